// ==== source/ce_pkg.sv ====
/*
  Shared types and constants for the FP16 computing element.
  Only round-toward-zero is modelled and subnormal values are treated as zero.
  Pipeline depth defaults to DEFAULT_PIPE_REGS and must be at least 1.
*/
package ce_pkg;

  // pipe depth used by the top level unless it is overridden.
  localparam int unsigned DEFAULT_PIPE_REGS = 2;

  localparam logic [15:0] FP16_QNAN         = 16'h7e00; // canonical quiet NaN.
  localparam logic [15:0] FP16_MAX_FINITE   = 16'h7bff; // largest finite magnitude.
  localparam logic [15:0] FP16_BIAS         = 16'd15;
  localparam logic [4:0]  FP16_EXP_ALL_ONES = 5'h1f;

  // One FP16 word, seen as fields by the multiplier and as raw bits by the comparator.
  typedef union packed {
    logic [15:0] bits;
    struct packed {
      logic       sign;
      logic [4:0] exponent;
      logic [9:0] mantissa;
    } fields;
  } fp16_u;

  typedef enum logic {
    OP1_MUL    = 1'b0,
    OP1_MINMAX = 1'b1
  } op1_e;

  typedef enum logic {
    OP2_NONE   = 1'b0, // stage 1 result goes straight to z.
    OP2_MINMAX = 1'b1
  } op2_e;

  typedef enum logic {
    MM_MIN = 1'b0,
    MM_MAX = 1'b1
  } minmax_e;

  // One request as offered by the source.
  typedef struct packed {
    fp16_u   x;
    fp16_u   w;
    fp16_u   y;
    op1_e    op1;
    op2_e    op2;
    minmax_e mm1;
    minmax_e mm2;
  } ce_req_t;

  // Fields that ride alongside stage 1 and are consumed by stage 2.
  typedef struct packed {
    fp16_u   y;
    op2_e    op2;
    minmax_e mm2;
  } stage2_side_t;

endpackage

// ==== source/fp16_mul.sv ====
/*
  Combinational FP16 multiplier, round toward zero only.
  Subnormal inputs and results flush to signed zero, overflow saturates
  to the largest finite value. No exception flags are produced.
*/
`timescale 1ns/100ps

module fp16_mul (
  input  ce_pkg::fp16_u a_i,
  input  ce_pkg::fp16_u b_i,
  output ce_pkg::fp16_u p_o
);
  import ce_pkg::*;

  logic               sign;
  logic               a_nan, b_nan;
  logic               a_inf, b_inf;
  logic               a_zero, b_zero;
  logic [21:0]        mant_prod;
  logic               norm_shift;
  logic [9:0]         mant_res;
  logic signed [7:0]  exp_sum;

  assign sign = a_i.fields.sign ^ b_i.fields.sign;

  assign a_nan  = (a_i.fields.exponent == FP16_EXP_ALL_ONES) && (a_i.fields.mantissa != '0);
  assign b_nan  = (b_i.fields.exponent == FP16_EXP_ALL_ONES) && (b_i.fields.mantissa != '0);
  assign a_inf  = (a_i.fields.exponent == FP16_EXP_ALL_ONES) && (a_i.fields.mantissa == '0);
  assign b_inf  = (b_i.fields.exponent == FP16_EXP_ALL_ONES) && (b_i.fields.mantissa == '0);
  assign a_zero = (a_i.fields.exponent == '0); // subnormals count as zero.
  assign b_zero = (b_i.fields.exponent == '0);

  // 11x11 product of the mantissas with their hidden bits restored.
  assign mant_prod  = {1'b1, a_i.fields.mantissa} * {1'b1, b_i.fields.mantissa};
  assign norm_shift = mant_prod[21]; // product lies in [2,4) and needs one right shift.

  // Truncation drops everything below the kept ten bits.
  assign mant_res = norm_shift ? mant_prod[20:11] : mant_prod[19:10];

  // Eight bits hold the full range from -13 up to 46 without wrapping.
  assign exp_sum = $signed({3'b000, a_i.fields.exponent} + {3'b000, b_i.fields.exponent}
                           + {7'b0000000, norm_shift} - FP16_BIAS[7:0]);

  always_comb begin
    p_o.bits = '0;
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
      p_o.bits = FP16_QNAN;
    end else if (a_inf || b_inf) begin
      p_o.fields.sign     = sign;
      p_o.fields.exponent = FP16_EXP_ALL_ONES;
      p_o.fields.mantissa = '0;
    end else if (a_zero || b_zero) begin
      p_o.fields.sign = sign; // signed zero.
    end else if (exp_sum > 8'sd30) begin
      p_o.bits      = FP16_MAX_FINITE; // saturate instead of going to infinity.
      p_o.bits[15]  = sign;
    end else if (exp_sum < 8'sd1) begin
      p_o.fields.sign = sign; // result would be subnormal or smaller.
    end else begin
      p_o.fields.sign     = sign;
      p_o.fields.exponent = exp_sum[4:0];
      p_o.fields.mantissa = mant_res;
    end
  end

endmodule

// ==== source/fp16_minmax.sv ====
/*
  Combinational FP16 minimum or maximum.
  -0 orders below +0. A single NaN input is ignored, two NaNs give the quiet NaN.
*/
`timescale 1ns/100ps

module fp16_minmax (
  input  ce_pkg::fp16_u   a_i,
  input  ce_pkg::fp16_u   b_i,
  input  ce_pkg::minmax_e mode_i,
  output ce_pkg::fp16_u   r_o
);
  import ce_pkg::*;

  logic        a_nan, b_nan;
  logic [15:0] a_key, b_key;
  logic        a_lt_b;

  assign a_nan = (a_i.fields.exponent == FP16_EXP_ALL_ONES) && (a_i.fields.mantissa != '0);
  assign b_nan = (b_i.fields.exponent == FP16_EXP_ALL_ONES) && (b_i.fields.mantissa != '0);

  // Map sign-magnitude onto an unsigned order so a plain compare works.
  assign a_key = a_i.bits[15] ? ~a_i.bits : (a_i.bits | 16'h8000);
  assign b_key = b_i.bits[15] ? ~b_i.bits : (b_i.bits | 16'h8000);
  assign a_lt_b = (a_key < b_key);

  always_comb begin
    if (a_nan && b_nan) begin
      r_o.bits = FP16_QNAN;
    end else if (a_nan) begin
      r_o = b_i;
    end else if (b_nan) begin
      r_o = a_i;
    end else if (mode_i == MM_MIN) begin
      r_o = a_lt_b ? a_i : b_i;
    end else begin
      r_o = a_lt_b ? b_i : a_i;
    end
  end

endmodule

// ==== source/ce_stage1.sv ====
/*
  Stage 1: multiply or min/max of x and w, then NumPipeRegs register stages.
  The whole pipe stalls together, there is no bubble collapsing.
  NumPipeRegs must be at least 1.
*/
`timescale 1ns/100ps

module ce_stage1 #(
  parameter int unsigned NumPipeRegs = ce_pkg::DEFAULT_PIPE_REGS
) (
  input  logic            stage2_noncomp_input_pipe_clk,
  input  logic            rst_ni,
  input  logic            in_valid_i,
  input  ce_pkg::ce_req_t req_i,
  input  logic            out_ready_i,
  output logic            advance_o,
  output ce_pkg::fp16_u   res_o,
  output logic            valid_o
);
  import ce_pkg::*;

  fp16_u                       mul_res;
  fp16_u                       mm_res;
  fp16_u                       sel_res;
  fp16_u [NumPipeRegs-1:0]     res_q;
  logic  [NumPipeRegs-1:0]     valid_q;

  fp16_mul u_mul (
    .a_i ( req_i.x ),
    .b_i ( req_i.w ),
    .p_o ( mul_res )
  );

  fp16_minmax u_minmax (
    .a_i    ( req_i.x   ),
    .b_i    ( req_i.w   ),
    .mode_i ( req_i.mm1 ),
    .r_o    ( mm_res    )
  );

  assign sel_res = (req_i.op1 == OP1_MINMAX) ? mm_res : mul_res;

  // The pipe may move whenever its last slot is free or is being drained.
  assign advance_o = ~valid_q[NumPipeRegs-1] | out_ready_i;

  always_ff @(posedge stage2_noncomp_input_pipe_clk, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance_o) begin
      valid_q[0] <= in_valid_i;
      for (int i = 1; i < NumPipeRegs; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // result words move through the same slots as their valid bits.
  always_ff @(posedge stage2_noncomp_input_pipe_clk) begin
    if (advance_o) begin
      res_q[0] <= sel_res;
      for (int i = 1; i < NumPipeRegs; i++) begin
        res_q[i] <= res_q[i-1];
      end
    end
  end

  assign res_o   = res_q[NumPipeRegs-1];
  assign valid_o = valid_q[NumPipeRegs-1];

endmodule

// ==== source/stage2_operand_pipe.sv ====
/*
  Delay line for the bias and the stage 2 opcodes.
  Moves under the same advance as stage 1 so each bias meets its own result.
*/
`timescale 1ns/100ps

module stage2_operand_pipe #(
  parameter int unsigned NumPipeRegs = ce_pkg::DEFAULT_PIPE_REGS
) (
  input  logic                 stage2_noncomp_input_pipe_clk,
  input  logic                 rst_ni,
  input  logic                 advance_i,
  input  ce_pkg::stage2_side_t side_i,
  output ce_pkg::stage2_side_t side_o
);
  import ce_pkg::*;

  stage2_side_t [NumPipeRegs-1:0] side_q;

  always_ff @(posedge stage2_noncomp_input_pipe_clk, negedge rst_ni) begin
    if (!rst_ni) begin
      side_q <= '0;
    end else if (advance_i) begin
      side_q[0] <= side_i;
      for (int i = 1; i < NumPipeRegs; i++) begin
        side_q[i] <= side_q[i-1]; // one slot per stage 1 register.
      end
    end
  end

  assign side_o = side_q[NumPipeRegs-1];

endmodule

// ==== source/ce_stage2.sv ====
/*
  Stage 2: min/max of the stage 1 result against the delayed bias,
  or the stage 1 result unchanged. Purely combinational.
*/
`timescale 1ns/100ps

module ce_stage2 (
  input  ce_pkg::fp16_u        res1_i,
  input  ce_pkg::stage2_side_t side_i,
  output ce_pkg::fp16_u        z_o
);
  import ce_pkg::*;

  fp16_u mm_res;

  fp16_minmax u_minmax (
    .a_i    ( res1_i     ),
    .b_i    ( side_i.y   ),
    .mode_i ( side_i.mm2 ),
    .r_o    ( mm_res     )
  );

  assign z_o = (side_i.op2 == OP2_MINMAX) ? mm_res : res1_i; // pass-through otherwise.

endmodule

// ==== source/redmule_ce_top.sv ====
/*
  FP16 computing element with valid/ready on both sides.
  Latency is NumPipeRegs cycles, results leave in order.
  A stalled output freezes the whole pipe and drops in_ready_o.
*/
`timescale 1ns/100ps

module redmule_ce_top #(
  parameter int unsigned NumPipeRegs = ce_pkg::DEFAULT_PIPE_REGS
) (
  input  logic            stage2_noncomp_input_pipe_clk,
  input  logic            rst_ni,
  input  logic            in_valid_i,
  input  ce_pkg::ce_req_t req_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  output ce_pkg::fp16_u   z_o,
  input  logic            out_ready_i
);
  import ce_pkg::*;

  logic         advance;
  fp16_u        stage1_res;
  stage2_side_t side_in;
  stage2_side_t side_dly;

  assign side_in = '{y: req_i.y, op2: req_i.op2, mm2: req_i.mm2};

  ce_stage1 #(
    .NumPipeRegs ( NumPipeRegs )
  ) u_stage1 (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni                        ( rst_ni                        ),
    .in_valid_i                    ( in_valid_i                    ),
    .req_i                         ( req_i                         ),
    .out_ready_i                   ( out_ready_i                   ),
    .advance_o                     ( advance                       ),
    .res_o                         ( stage1_res                    ),
    .valid_o                       ( out_valid_o                   )
  );

  stage2_operand_pipe #(
    .NumPipeRegs ( NumPipeRegs )
  ) u_side_pipe (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni                        ( rst_ni                        ),
    .advance_i                     ( advance                       ),
    .side_i                        ( side_in                       ),
    .side_o                        ( side_dly                      )
  );

  ce_stage2 u_stage2 (
    .res1_i ( stage1_res ),
    .side_i ( side_dly   ),
    .z_o    ( z_o        )
  );

  assign in_ready_o = advance; // a request enters only when the pipe moves.

endmodule

// ==== tb/ce_props.sv ====
/*
  Handshake and reset properties, bound to the computing element top level.
  failures counts the failed assertions so the testbench can include them.
*/
`timescale 1ns/100ps

module ce_props (
  input logic          stage2_noncomp_input_pipe_clk,
  input logic          rst_ni,
  input logic          in_ready_i,
  input logic          out_valid_i,
  input logic          out_ready_i,
  input ce_pkg::fp16_u z_i
);

  int failures = 0;

  // no result may be offered while reset is held or on the edge after it.
  valid_low_in_reset: assert property (@(posedge stage2_noncomp_input_pipe_clk)
    !rst_ni |=> !out_valid_i)
    else begin
      failures++;
      $error("out_valid_o was high during or right after reset");
    end

  stall_holds_output: assert property (@(posedge stage2_noncomp_input_pipe_clk)
    disable iff (!rst_ni) (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(z_i)))
    else begin
      failures++;
      $error("a stalled result changed or was withdrawn");
    end

  ready_when_empty: assert property (@(posedge stage2_noncomp_input_pipe_clk)
    disable iff (!rst_ni) !out_valid_i |-> in_ready_i)
    else begin
      failures++;
      $error("in_ready_o was low although no result was waiting");
    end

endmodule

bind redmule_ce_top ce_props u_props (
  .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
  .rst_ni                        ( rst_ni                        ),
  .in_ready_i                    ( in_ready_o                    ),
  .out_valid_i                   ( out_valid_o                   ),
  .out_ready_i                   ( out_ready_i                   ),
  .z_i                           ( z_o                           )
);

// ==== tb/ce_checker.sv ====
/*
  Scoreboard for the computing element. Expected values are queued on each input
  transfer and compared, in order, on each output transfer.
*/
`timescale 1ns/100ps

module ce_checker #(
  parameter int unsigned NameBits = 96
) (
  input  logic                stage2_noncomp_input_pipe_clk,
  input  logic                rst_ni,
  input  logic                in_valid_i,
  input  logic                in_ready_i,
  input  logic                out_valid_i,
  input  logic                out_ready_i,
  input  ce_pkg::fp16_u       z_i,
  input  logic [15:0]         exp_z_i,
  input  logic [NameBits-1:0] name_i,
  output int                  checked_o,
  output int                  mismatches_o,
  output int                  proto_errors_o
);

  logic [15:0]         exp_q[$];
  logic [NameBits-1:0] name_q[$];

  // The falling edge sees every handshake signal as it will be at the next rising edge.
  always @(negedge stage2_noncomp_input_pipe_clk) begin
    logic [15:0]         expected;
    logic [NameBits-1:0] tname;
    if (!rst_ni) begin
      checked_o      = 0;
      mismatches_o   = 0;
      proto_errors_o = 0;
      exp_q.delete();
      name_q.delete();
    end else begin
      // Outputs are served before new inputs, so a spurious result cannot take a fresh entry.
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          proto_errors_o++;
          $display("error: the core delivered a result %h that no request asked for", z_i.bits);
        end else begin
          expected = exp_q.pop_front();
          tname    = name_q.pop_front();
          checked_o++;
          if (z_i.bits !== expected) begin
            mismatches_o++;
            $display("[FAIL] %0s: expected %h, actual %h", tname, expected, z_i.bits);
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        exp_q.push_back(exp_z_i);
        name_q.push_back(name_i);
      end
    end
  end

endmodule

// ==== tb/tb_redmule_ce.sv ====
/*
  Testbench for the FP16 computing element. A table of requests is driven in order
  while out_ready toggles at random. Expected results were worked out by hand from
  the FP16 rules of the core (round toward zero, subnormals flushed to zero).
*/
`timescale 1ns/100ps

module tb_redmule_ce;
  import ce_pkg::*;

  localparam int unsigned NumPipeRegs = DEFAULT_PIPE_REGS;
  localparam int unsigned NameBits    = 8 * 12; // up to twelve characters per test name.

  logic                stage2_noncomp_input_pipe_clk;
  logic                rst_ni;
  logic                in_valid, in_ready, out_valid, out_ready;
  ce_req_t             req;
  fp16_u               z;
  logic [15:0]         exp_z;
  logic [NameBits-1:0] name;
  int                  checked, mismatches, proto_errors;
  int                  seed = 32'h10dc5da4;
  bit                  table_ready = 1'b0;
  ce_req_t             reqs[$];
  logic [15:0]         exps[$];
  logic [NameBits-1:0] names[$];

  redmule_ce_top #(
    .NumPipeRegs ( NumPipeRegs )
  ) dut0 (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni                        ( rst_ni                        ),
    .in_valid_i                    ( in_valid                      ),
    .req_i                         ( req                           ),
    .in_ready_o                    ( in_ready                      ),
    .out_valid_o                   ( out_valid                     ),
    .z_o                           ( z                             ),
    .out_ready_i                   ( out_ready                     )
  );

  ce_checker #(
    .NameBits ( NameBits )
  ) u_checker (
    .stage2_noncomp_input_pipe_clk ( stage2_noncomp_input_pipe_clk ),
    .rst_ni         ( rst_ni       ),
    .in_valid_i     ( in_valid     ),
    .in_ready_i     ( in_ready     ),
    .out_valid_i    ( out_valid    ),
    .out_ready_i    ( out_ready    ),
    .z_i            ( z            ),
    .exp_z_i        ( exp_z        ),
    .name_i         ( name         ),
    .checked_o      ( checked      ),
    .mismatches_o   ( mismatches   ),
    .proto_errors_o ( proto_errors )
  );

  always #20 stage2_noncomp_input_pipe_clk = ~stage2_noncomp_input_pipe_clk;

  // Sink readiness changes shortly after every rising edge, ready about three times in four.
  always @(posedge stage2_noncomp_input_pipe_clk) begin
    #2;
    out_ready = (($random(seed) & 3) != 0);
  end

  task automatic store_case(input logic [NameBits-1:0] n, input ce_req_t r,
                            input logic [15:0] z_exp);
    names.push_back(n);
    reqs.push_back(r);
    exps.push_back(z_exp);
  endtask

  // stage 2 passes the stage 1 result through.
  task automatic stage1_case(input logic [NameBits-1:0] n, input logic [15:0] a, b,
                             input op1_e op1, input minmax_e mm1, input logic [15:0] z_exp);
    store_case(n, '{x: a, w: b, y: 16'h0000, op1: op1, op2: OP2_NONE, mm1: mm1, mm2: MM_MIN},
               z_exp);
  endtask

  task automatic bias_case(input logic [NameBits-1:0] n, input logic [15:0] a, b,
                           input op1_e op1, input minmax_e mm1, input logic [15:0] bias,
                           input minmax_e mm2, input logic [15:0] z_exp);
    store_case(n, '{x: a, w: b, y: bias, op1: op1, op2: OP2_MINMAX, mm1: mm1, mm2: mm2},
               z_exp);
  endtask

  // Offers one table entry and holds it until the core accepts it.
  task automatic drive_request(input int idx);
    in_valid = 1'b1;
    req      = reqs[idx];
    exp_z    = exps[idx];
    name     = names[idx];
    do begin
      @(negedge stage2_noncomp_input_pipe_clk); // in_ready is settled for the next edge here.
    end while (!in_ready);
    @(posedge stage2_noncomp_input_pipe_clk);
    #2;
  endtask

  initial begin
    stage2_noncomp_input_pipe_clk = 1'b0;
    rst_ni    = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    req       = '0;
    exp_z     = '0;
    name      = '0;
    stage1_case("mul_3p0",    16'h3e00, 16'h4000, OP1_MUL, MM_MIN, 16'h4200);
    stage1_case("mul_negmix", 16'hbe00, 16'h4000, OP1_MUL, MM_MIN, 16'hc200);
    stage1_case("mul_negsq",  16'h3e00, 16'hbe00, OP1_MUL, MM_MIN, 16'hc080);
    stage1_case("mul_trunc",  16'h3c01, 16'h3c01, OP1_MUL, MM_MIN, 16'h3c02);
    stage1_case("mul_ovf",    16'h7bff, 16'h4000, OP1_MUL, MM_MIN, 16'h7bff);
    stage1_case("mul_negovf", 16'hfbff, 16'h4000, OP1_MUL, MM_MIN, 16'hfbff);
    stage1_case("mul_subn",   16'h8001, 16'h4000, OP1_MUL, MM_MIN, 16'h8000);
    stage1_case("mul_unf",    16'h0400, 16'h3800, OP1_MUL, MM_MIN, 16'h0000);
    stage1_case("mul_infx0",  16'h7c00, 16'h0000, OP1_MUL, MM_MIN, 16'h7e00);
    stage1_case("mul_infxn2", 16'h7c00, 16'hc000, OP1_MUL, MM_MIN, 16'hfc00);
    stage1_case("mul_nan",    16'h7c01, 16'h3c00, OP1_MUL, MM_MIN, 16'h7e00);
    stage1_case("min_zeros",  16'h8000, 16'h0000, OP1_MINMAX, MM_MIN, 16'h8000);
    stage1_case("max_zeros",  16'h8000, 16'h0000, OP1_MINMAX, MM_MAX, 16'h0000);
    stage1_case("min_onenan", 16'h7e00, 16'h3c00, OP1_MINMAX, MM_MIN, 16'h3c00);
    stage1_case("max_twonan", 16'h7c01, 16'hfe00, OP1_MINMAX, MM_MAX, 16'h7e00);
    stage1_case("min_neg",    16'hc000, 16'h3c00, OP1_MINMAX, MM_MIN, 16'hc000);
    stage1_case("max_neg",    16'hc000, 16'hc400, OP1_MINMAX, MM_MAX, 16'hc000);
    // back-to-back products of 3.0 meet different biases.
    bias_case("bias_max4", 16'h3e00, 16'h4000, OP1_MUL, MM_MIN, 16'h4400, MM_MAX, 16'h4400);
    bias_case("bias_max1", 16'h3e00, 16'h4000, OP1_MUL, MM_MIN, 16'h3c00, MM_MAX, 16'h4200);
    bias_case("bias_min1", 16'h3e00, 16'h4000, OP1_MUL, MM_MIN, 16'h3c00, MM_MIN, 16'h3c00);
    bias_case("bias_minn2", 16'h4000, 16'h4000, OP1_MUL, MM_MIN, 16'hc000, MM_MIN, 16'hc000);
    bias_case("bias_nan", 16'h3c00, 16'hbc00, OP1_MUL, MM_MIN, 16'h7e00, MM_MIN, 16'hbc00);
    bias_case("mm_then_mx", 16'h3c00, 16'h4000, OP1_MINMAX, MM_MIN, 16'h4200, MM_MAX, 16'h4200);
    table_ready = 1'b1;
    repeat (5) @(posedge stage2_noncomp_input_pipe_clk);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < reqs.size(); i++) begin
      drive_request(i);
    end
    in_valid = 1'b0;
    wait (checked == reqs.size());
    repeat (2 * (NumPipeRegs + 1)) @(posedge stage2_noncomp_input_pipe_clk); // stray outputs.
    $display("results %0d of %0d, mismatches %0d, protocol errors %0d, assertion failures %0d",
             checked, reqs.size(), mismatches, proto_errors, dut0.u_props.failures);
    if (mismatches == 0 && proto_errors == 0 && dut0.u_props.failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = reqs.size() * (NumPipeRegs + 1) * 4 + 50;
    repeat (limit) @(posedge stage2_noncomp_input_pipe_clk);
    $display("timeout: the results did not all arrive within %0d clock cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
source/ce_pkg.sv
source/fp16_mul.sv
source/fp16_minmax.sv
source/ce_stage1.sv
source/stage2_operand_pipe.sv
source/ce_stage2.sv
source/redmule_ce_top.sv
tb/ce_props.sv
tb/ce_checker.sv
tb/tb_redmule_ce.sv

// ==== Bender.yml ====
package:
  name: redmule_ce

sources:
  - source/ce_pkg.sv
  - source/fp16_mul.sv
  - source/fp16_minmax.sv
  - source/ce_stage1.sv
  - source/stage2_operand_pipe.sv
  - source/ce_stage2.sv
  - source/redmule_ce_top.sv
  - target: test
    files:
      - tb/ce_props.sv
      - tb/ce_checker.sv
      - tb/tb_redmule_ce.sv
